/* design/bitonic_merge_8.sv */
module bitonic_merge_8
   import sort_key_pkg::*, merge_ctrl_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_reset,
   // candidate tuples from the two FIFO heads.
   input  tuple_t i_a_head,
   input  tuple_t i_b_head,
   input  side_t  i_side,
   input  logic   i_take,
   input  logic   i_fill,
   output logic   o_net_ready,
   // output register.
   output logic   o_valid,
   output tuple_t o_tuple,
   input  logic   i_ready
);

   localparam int LAYERS = $clog2(MERGE_N);

   tuple_t chosen;
   tuple_t hold_q;          // four largest keys seen but not yet emitted.
   tuple_t out_q;
   logic   out_valid;
   tuple_t lo_tuple;
   tuple_t hi_tuple;

   key_t net [0:LAYERS][0:MERGE_N-1];

   assign chosen = (i_side == SIDE_A) ? i_a_head : i_b_head;

   // free slot now, or the current one leaves on this edge.
   assign o_net_ready = !out_valid || i_ready;

   assign o_valid = out_valid;
   assign o_tuple = out_q;

   // held tuple ascending, chosen tuple reversed, gives a bitonic sequence.
   // then three half-cleaner layers with strides 4, 2, 1.
   always_comb begin
      int stride;
      int lo;
      int hi;
      for (int k = 0; k < TUPLE_N; k++) begin
         net[0][k]         = tuple_key(hold_q, k);
         net[0][TUPLE_N+k] = tuple_key(chosen, TUPLE_N-1-k);
      end
      for (int l = 0; l < LAYERS; l++) begin
         stride = TUPLE_N >> l;
         for (int j = 0; j < TUPLE_N; j++) begin
            lo = (j / stride) * 2 * stride + (j % stride);
            hi = lo + stride;
            if (net[l][lo] <= net[l][hi]) begin
               net[l+1][lo] = net[l][lo];
               net[l+1][hi] = net[l][hi];
            end else begin
               net[l+1][lo] = net[l][hi];    // swap.
               net[l+1][hi] = net[l][lo];
            end
         end
      end
      for (int k = 0; k < TUPLE_N; k++) begin
         lo_tuple[k*KEY_W +: KEY_W] = net[LAYERS][k];
         hi_tuple[k*KEY_W +: KEY_W] = net[LAYERS][TUPLE_N+k];
      end
   end

   // payload.
   always_ff @(posedge i_clk) begin
      if (i_take) begin
         if (i_fill) begin
            hold_q <= chosen;                // nothing to merge with yet.
         end else begin
            hold_q <= hi_tuple;
            out_q  <= lo_tuple;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_valid <= 1'b0;
      end else if (i_take && !i_fill) begin
         out_valid <= 1'b1;
      end else if (i_ready) begin
         out_valid <= 1'b0;
      end
   end

   // relies on both input streams being sorted and on the pick rule.
   a_out_sorted: assert property (
      @(posedge i_clk) disable iff (i_reset)
      out_valid |-> tuple_sorted(out_q)
   ) else $error("bitonic_merge_8: emitted tuple out of order");

endmodule

/* design/merge_ctrl_pkg.sv */
package merge_ctrl_pkg;

   // selector states.
   // FILL until the first tuple is held back, then MERGE for good.
   typedef enum logic [1:0] {
      FILL  = 2'd0,
      MERGE = 2'd1
   } sel_state_t;

   // which input FIFO was popped.
   typedef enum logic {
      SIDE_A = 1'b0,
      SIDE_B = 1'b1
   } side_t;

endpackage

/* design/merge_select.sv */
module merge_select
   import sort_key_pkg::*, merge_ctrl_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_reset,
   // FIFO heads.
   input  tuple_t i_a_head,
   input  logic   i_a_nonempty,
   input  tuple_t i_b_head,
   input  logic   i_b_nonempty,
   // network handshake.
   input  logic   i_net_ready,
   output logic   o_a_pop,
   output logic   o_b_pop,
   output side_t  o_side,
   output logic   o_take,
   output logic   o_fill
);

   sel_state_t state;
   sel_state_t state_nxt;

   key_t a_min;
   key_t b_min;
   logic a_first;
   logic both_ready;
   logic pop_en;

   // smallest key of each head.
   assign a_min = tuple_key(i_a_head, 0);
   assign b_min = tuple_key(i_b_head, 0);

   // ties go to A.
   assign a_first = (a_min <= b_min);

   // both heads must be known before we may choose.
   assign both_ready = i_a_nonempty && i_b_nonempty;
   assign pop_en     = both_ready && i_net_ready;

   assign o_side  = a_first ? SIDE_A : SIDE_B;
   assign o_a_pop = pop_en && a_first;
   assign o_b_pop = pop_en && !a_first;
   assign o_take  = o_a_pop || o_b_pop;

   // network loads instead of merging while no tuple is held back.
   assign o_fill = (state == FILL);

   always_comb begin
      state_nxt = state;
      case (state)
         FILL: begin
            if (o_take) state_nxt = MERGE;    // first tuple now held back.
         end
         MERGE: begin
            state_nxt = MERGE;
         end
         default: begin
            state_nxt = FILL;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) state <= FILL;
      else state <= state_nxt;
   end

   // the network needs every popped tuple in ascending key order.
   a_head_sorted: assert property (
      @(posedge i_clk) disable iff (i_reset)
      o_take |-> tuple_sorted((o_side == SIDE_A) ? i_a_head : i_b_head)
   ) else $error("merge_select: popped tuple not in key order");

endmodule

/* design/merger_4.sv */
module merger_4
   import sort_key_pkg::*, merge_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic   i_clk,
   input  logic   i_reset,
   // input stream A.
   input  logic   i_a_valid,
   input  tuple_t i_a_tuple,
   output logic   o_a_ready,
   // input stream B.
   input  logic   i_b_valid,
   input  tuple_t i_b_tuple,
   output logic   o_b_ready,
   // merged output.
   output logic   o_valid,
   output tuple_t o_tuple,
   input  logic   i_ready
);

   tuple_t a_head;
   tuple_t b_head;
   logic   a_nonempty;
   logic   b_nonempty;
   logic   a_pop;
   logic   b_pop;
   side_t  sel_side;
   logic   take;
   logic   fill;
   logic   net_ready;

   tuple_fifo #(.DEPTH(FIFO_DEPTH)) fifo_a (
      .i_clk(i_clk), .i_reset(i_reset),
      .i_valid(i_a_valid), .i_tuple(i_a_tuple), .o_ready(o_a_ready),
      .i_pop(a_pop), .o_head(a_head), .o_nonempty(a_nonempty)
   );

   tuple_fifo #(.DEPTH(FIFO_DEPTH)) fifo_b (
      .i_clk(i_clk), .i_reset(i_reset),
      .i_valid(i_b_valid), .i_tuple(i_b_tuple), .o_ready(o_b_ready),
      .i_pop(b_pop), .o_head(b_head), .o_nonempty(b_nonempty)
   );

   merge_select select_i (
      .i_clk(i_clk), .i_reset(i_reset),
      .i_a_head(a_head), .i_a_nonempty(a_nonempty),
      .i_b_head(b_head), .i_b_nonempty(b_nonempty),
      .i_net_ready(net_ready),
      .o_a_pop(a_pop), .o_b_pop(b_pop),
      .o_side(sel_side), .o_take(take), .o_fill(fill)
   );

   bitonic_merge_8 network_i (
      .i_clk(i_clk), .i_reset(i_reset),
      .i_a_head(a_head), .i_b_head(b_head),
      .i_side(sel_side), .i_take(take), .i_fill(fill),
      .o_net_ready(net_ready),
      .o_valid(o_valid), .o_tuple(o_tuple), .i_ready(i_ready)
   );

endmodule

/* design/sort_key_pkg.sv */
package sort_key_pkg;

   // key and tuple geometry.
   localparam int KEY_W   = 32;
   localparam int TUPLE_N = 4;
   localparam int TUPLE_W = KEY_W * TUPLE_N;
   localparam int MERGE_N = 2 * TUPLE_N;       // keys seen by the merge network.

   typedef logic [KEY_W-1:0]   key_t;
   typedef logic [TUPLE_W-1:0] tuple_t;         // key 0 in the low bits, smallest.

   // pick key k out of a packed tuple.
   function automatic key_t tuple_key(input tuple_t t, input int k);
      return t[k*KEY_W +: KEY_W];
   endfunction

   // true when keys run non-decreasing from key 0 upward.
   function automatic logic tuple_sorted(input tuple_t t);
      logic ok;
      ok = 1'b1;
      for (int k = 1; k < TUPLE_N; k++) ok &= (tuple_key(t, k-1) <= tuple_key(t, k));
      return ok;
   endfunction

endpackage

/* design/tuple_fifo.sv */
module tuple_fifo
   import sort_key_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic   i_clk,
   input  logic   i_reset,
   // write side.
   input  logic   i_valid,
   input  tuple_t i_tuple,
   output logic   o_ready,
   // read side.
   input  logic   i_pop,
   output tuple_t o_head,
   output logic   o_nonempty
);

   localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [ADDR_W:0] CNT_FULL = (ADDR_W+1)'(DEPTH);

   tuple_t            mem [0:DEPTH-1];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W:0]   count;
   logic              wr_en;

   // a pop in the same cycle frees the slot, so full does not block.
   assign o_ready    = (count != CNT_FULL) || i_pop;
   assign wr_en      = i_valid && o_ready;
   assign o_head     = mem[rd_ptr];
   assign o_nonempty = (count != '0);

   always_ff @(posedge i_clk) begin
      if (wr_en) mem[wr_ptr] <= i_tuple;
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two.
         if (i_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // selector must only pop a FIFO that holds a tuple.
   a_no_pop_empty: assert property (
      @(posedge i_clk) disable iff (i_reset)
      i_pop |-> (count != '0)
   ) else $error("tuple_fifo: pop while empty");

   a_count_bound: assert property (
      @(posedge i_clk) disable iff (i_reset)
      count <= CNT_FULL
   ) else $error("tuple_fifo: occupancy above depth");

endmodule

/* run_sim.sh */
#!/bin/sh
# build the merger testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   --top-module merger_4_tb \
   --Mdir obj_dir -o merger_4_sim \
   -f sim.f

run_status=0
./obj_dir/merger_4_sim > "$LOG" 2>&1 || run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
if [ "$run_status" -ne 0 ] || ! grep -q "Simulation passed" "$LOG"; then
   echo "simulation did not run to completion, see $LOG"
   exit 1
fi
exit 0

/* sim.f */
design/sort_key_pkg.sv
design/merge_ctrl_pkg.sv
design/tuple_fifo.sv
design/merge_select.sv
design/bitonic_merge_8.sv
design/merger_4.sv
test/merger_4_tb.sv

/* test/merger_4_tb.sv */
module merger_4_tb
   import sort_key_pkg::*;
();

   localparam int PERIOD  = 40;
   localparam int FIFO_D  = 4;
   localparam int RST_CYC = 5;
   localparam int LIMIT   = 2000;    // cycles per wait loop.
   localparam int HOLD    = 30;      // back-pressure length.

   logic   i_clk;
   logic   i_reset;
   logic   i_a_valid;
   tuple_t i_a_tuple;
   logic   o_a_ready;
   logic   i_b_valid;
   tuple_t i_b_tuple;
   logic   o_b_ready;
   logic   o_valid;
   tuple_t o_tuple;
   logic   i_ready;

   integer seed;
   int     errors;
   int     timeouts;
   int     checks;

   key_t   ref_keys[$];     // every key of both streams, ascending.
   tuple_t a_q[$];
   tuple_t b_q[$];
   int     a_idx;           // tuples accepted per side.
   int     b_idx;
   int     out_idx;
   logic   a_pending;
   logic   b_pending;
   logic   valid_rand;
   int     ready_mode;      // 0 ready, 1 held low, 2 random.

   merger_4 #(.FIFO_DEPTH(FIFO_D)) merger_4_i (
      .i_clk(i_clk), .i_reset(i_reset),
      .i_a_valid(i_a_valid), .i_a_tuple(i_a_tuple), .o_a_ready(o_a_ready),
      .i_b_valid(i_b_valid), .i_b_tuple(i_b_tuple), .o_b_ready(o_b_ready),
      .o_valid(o_valid), .o_tuple(o_tuple), .i_ready(i_ready)
   );

   always #(PERIOD/2) i_clk = ~i_clk;

   task automatic check_tuple(input tuple_t got, input tuple_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   function automatic tuple_t make_ramp(input key_t start, input key_t step);
      tuple_t t;
      for (int k = 0; k < TUPLE_N; k++) t[k*KEY_W +: KEY_W] = start + key_t'(k) * step;
      return t;
   endfunction

   task automatic add_reference(input key_t k);
      int pos;
      pos = ref_keys.size();
      while (pos > 0 && ref_keys[pos-1] > k) pos--;
      ref_keys.insert(pos, k);
   endtask

   // pops follow the smaller lowest key, ties to A, until one side runs dry.
   function automatic int expected_outputs();
      int i;
      int j;
      i = 0;
      j = 0;
      while (i < a_q.size() && j < b_q.size()) begin
         if (a_q[i][KEY_W-1:0] <= b_q[j][KEY_W-1:0]) i++;
         else j++;
      end
      return (i + j > 0) ? i + j - 1 : 0;   // first pop only fills.
   endfunction

   task automatic check_output(input tuple_t got);
      tuple_t exp;
      logic   ord;
      int     base;
      base = out_idx * TUPLE_N;
      if (base + TUPLE_N > ref_keys.size()) begin
         errors++;
         $display("Output tuple %0d arrived with no reference keys left for it", out_idx);
      end else begin
         for (int k = 0; k < TUPLE_N; k++) exp[k*KEY_W +: KEY_W] = ref_keys[base+k];
         check_tuple(got, exp, $sformatf("output tuple %0d", out_idx));
      end
      ord = 1'b1;
      for (int k = 1; k < TUPLE_N; k++) begin
         if (got[(k-1)*KEY_W +: KEY_W] > got[k*KEY_W +: KEY_W]) ord = 1'b0;
      end
      check_flag(ord, 1'b1, $sformatf("output tuple %0d key order", out_idx));
      out_idx++;
   endtask

   // transfers happen here, pre-edge values.
   always @(posedge i_clk) begin
      if (!i_reset) begin
         if (i_a_valid && o_a_ready) begin
            a_idx++;
            a_pending = 1'b0;
         end
         if (i_b_valid && o_b_ready) begin
            b_idx++;
            b_pending = 1'b0;
         end
         if (o_valid && i_ready) check_output(o_tuple);
      end
   end

   task automatic apply_reset();
      @(negedge i_clk);
      i_reset   = 1'b1;
      i_a_valid = 1'b0;
      i_b_valid = 1'b0;
      i_a_tuple = '0;
      i_b_tuple = '0;
      i_ready   = 1'b0;
      a_idx     = 0;
      b_idx     = 0;
      out_idx   = 0;
      a_pending = 1'b0;
      b_pending = 1'b0;
      repeat (RST_CYC) @(negedge i_clk);
      i_reset = 1'b0;
   endtask

   task automatic start_run();
      ref_keys.delete();
      foreach (a_q[t]) for (int k = 0; k < TUPLE_N; k++) add_reference(a_q[t][k*KEY_W +: KEY_W]);
      foreach (b_q[t]) for (int k = 0; k < TUPLE_N; k++) add_reference(b_q[t][k*KEY_W +: KEY_W]);
      apply_reset();
   endtask

   // one falling edge of stimulus. data holds until the monitor sees it taken.
   task automatic drive_cycle();
      @(negedge i_clk);
      if (!a_pending) begin
         if (a_idx < a_q.size() && (!valid_rand || ($random(seed) & 1) != 0)) begin
            i_a_valid = 1'b1;
            i_a_tuple = a_q[a_idx];
            a_pending = 1'b1;
         end else begin
            i_a_valid = 1'b0;
         end
      end
      if (!b_pending) begin
         if (b_idx < b_q.size() && (!valid_rand || ($random(seed) & 1) != 0)) begin
            i_b_valid = 1'b1;
            i_b_tuple = b_q[b_idx];
            b_pending = 1'b1;
         end else begin
            i_b_valid = 1'b0;
         end
      end
      case (ready_mode)
         0: i_ready = 1'b1;
         1: i_ready = 1'b0;
         default: i_ready = ($random(seed) & 1) != 0;
      endcase
   endtask

   task automatic run_until_done(input string name);
      int target;
      int n;
      target = expected_outputs();
      n = 0;
      while (out_idx < target && n < LIMIT) begin
         drive_cycle();
         n++;
      end
      if (out_idx < target) begin
         timeouts++;
         $display("Timeout in %s test: only %0d of %0d output tuples seen", name, out_idx, target);
      end else begin
         ready_mode = 1;                  // a surplus tuple stays in the output register.
         repeat (2 * FIFO_D) drive_cycle();
         check_flag(o_valid, 1'b0, $sformatf("o_valid after the last %s tuple", name));
      end
   endtask

   task automatic reset_state_test();
      a_q.delete();
      b_q.delete();
      ready_mode = 0;
      valid_rand = 1'b0;
      start_run();
      check_flag(o_valid, 1'b0, "o_valid after reset");
      check_flag(o_a_ready, 1'b1, "o_a_ready after reset");
      check_flag(o_b_ready, 1'b1, "o_b_ready after reset");
   endtask

   task automatic interleaved_test();
      a_q.delete();
      b_q.delete();
      for (int t = 0; t < 4; t++) begin
         a_q.push_back(make_ramp(key_t'(1 + 8*t), 2));    // odd keys.
         b_q.push_back(make_ramp(key_t'(2 + 8*t), 2));
      end
      ready_mode = 0;
      valid_rand = 1'b0;
      start_run();
      run_until_done("interleaved");
   endtask

   task automatic lopsided_test();
      a_q.delete();
      b_q.delete();
      for (int t = 0; t < 3; t++) a_q.push_back(make_ramp(key_t'(4*t), 1));
      a_q.push_back(make_ramp(20, 0));                    // equal heads, A wins.
      b_q.push_back(make_ramp(20, 0));
      for (int t = 0; t < 3; t++) b_q.push_back(make_ramp(key_t'(21 + 8*t), 2));
      ready_mode = 0;
      valid_rand = 1'b0;
      start_run();
      run_until_done("lopsided");
   endtask

   task automatic backpressure_test();
      tuple_t held;
      int     n;
      a_q.delete();
      b_q.delete();
      for (int t = 0; t < 8; t++) begin
         a_q.push_back(make_ramp(key_t'(8*t), 2));
         b_q.push_back(make_ramp(key_t'(8*t + 1), 2));
      end
      ready_mode = 1;
      valid_rand = 1'b0;
      start_run();
      n = 0;
      while (!o_valid && n < LIMIT) begin
         drive_cycle();
         n++;
      end
      if (!o_valid) begin
         timeouts++;
         $display("Timeout in backpressure test: no output tuple appeared");
      end else begin
         // first tuple of the sorted union.
         for (int k = 0; k < TUPLE_N; k++) held[k*KEY_W +: KEY_W] = ref_keys[k];
         repeat (HOLD) begin
            drive_cycle();
            #(PERIOD/4);
            check_flag(o_valid, 1'b1, "o_valid under back-pressure");
            check_tuple(o_tuple, held, "o_tuple under back-pressure");
         end
         check_flag(o_a_ready, 1'b0, "o_a_ready with FIFO A full");
         check_flag(o_b_ready, 1'b0, "o_b_ready with FIFO B full");
      end
      ready_mode = 0;
      run_until_done("backpressure");
   endtask

   task automatic random_test();
      tuple_t t;
      key_t   run;
      a_q.delete();
      b_q.delete();
      run = 0;
      for (int n = 0; n < 12; n++) begin
         for (int k = 0; k < TUPLE_N; k++) begin
            run = run + key_t'($random(seed) & 7);   // small steps, so ties happen.
            t[k*KEY_W +: KEY_W] = run;
         end
         a_q.push_back(t);
      end
      run = 0;
      for (int n = 0; n < 12; n++) begin
         for (int k = 0; k < TUPLE_N; k++) begin
            run = run + key_t'($random(seed) & 7);
            t[k*KEY_W +: KEY_W] = run;
         end
         b_q.push_back(t);
      end
      ready_mode = 2;
      valid_rand = 1'b1;
      start_run();
      run_until_done("random");
   endtask

   initial begin
      seed       = 50447;
      errors     = 0;
      timeouts   = 0;
      checks     = 0;
      i_clk      = 1'b0;
      i_reset    = 1'b1;
      i_a_valid  = 1'b0;
      i_a_tuple  = '0;
      i_b_valid  = 1'b0;
      i_b_tuple  = '0;
      i_ready    = 1'b0;
      a_pending  = 1'b0;
      b_pending  = 1'b0;
      valid_rand = 1'b0;
      ready_mode = 0;
      reset_state_test();
      interleaved_test();
      lopsided_test();
      backpressure_test();
      random_test();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
